// ==== vlog.f ====
+incdir+.
wb_pkg.sv
wb_lanes.sv
wb_arbiter.sv
wb_cdb_rf.sv
wb_top.sv
tb_wb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the writeback testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_wb -f vlog.f -o tb_wb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/tb_wb_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "FAIL: see errors above" "$SIM_LOG"; then
  echo "simulation failed"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

echo "simulation passed"
exit 0

// ==== tb_wb.sv ====
////////////////////////////////////////
// writeback stage testbench
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "wb_settings.svh"

module tb_wb;

  // tests need about 400 cycles, run is cut off well above that
  localparam int max_cycles = 600;
  localparam int rf_depth = 1 << `WB_RD_W;

  logic clk = 1'b0;
  logic rst_n;
  logic rob_flush;
  wb_pkg::wb_result_t src [`WB_NUM_LANES];
  wb_pkg::wb_result_t csr_in;
  wb_pkg::rd_t        rf_raddr;
  wb_pkg::wb_result_t cdb_out;
  wb_pkg::data_t      rf_rdata;
  logic               scalu0_stall;
  logic               scalu1_stall;
  logic               mcalu0_stall;
  logic               mcalu1_stall;
  logic               lsq_stall;
  wb_pkg::lane_vec_t  dut_stall;

  // reference model state
  wb_pkg::wb_result_t model_q [`WB_NUM_LANES];
  wb_pkg::wb_result_t model_cdb;
  wb_pkg::lane_vec_t  model_valid;
  wb_pkg::lane_vec_t  model_stall;
  int                 win;
  wb_pkg::data_t      shadow [rf_depth];
  logic [rf_depth-1:0] written = '0;
  wb_pkg::rd_t        last_rd = '0;

  integer             seed = 1978;
  int                 errors = 0;
  int                 cycle_cnt = 0;
  logic               check_en = 1'b0;
  logic [31:0]        rnd;
  wb_pkg::wb_result_t r;

  always #20 clk = ~clk;

  wb_top dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .rob_flush    (rob_flush),
    .scalu0_in    (src[0]),
    .scalu1_in    (src[1]),
    .mcalu0_in    (src[2]),
    .mcalu1_in    (src[3]),
    .lsq_in       (src[4]),
    .csr_in       (csr_in),
    .scalu0_stall (scalu0_stall),
    .scalu1_stall (scalu1_stall),
    .mcalu0_stall (mcalu0_stall),
    .mcalu1_stall (mcalu1_stall),
    .lsq_stall    (lsq_stall),
    .cdb_out      (cdb_out),
    .rf_raddr     (rf_raddr),
    .rf_rdata     (rf_rdata)
  );

  assign dut_stall = {lsq_stall, mcalu1_stall, mcalu0_stall, scalu1_stall, scalu0_stall};

  // scan from lsq down, first valid lane wins
  function automatic int highest_valid(wb_pkg::lane_vec_t v);
    for (int i = `WB_NUM_LANES - 1; i >= 0; i--) begin
      if (v[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic wb_pkg::wb_result_t make_result(bit allow_error);
    wb_pkg::wb_result_t res;
    logic [31:0]        tmp;
    tmp = $random(seed);
    res.valid  = 1'b1;
    res.error  = allow_error && (tmp[2:0] == 3'd0);
    res.ecause = tmp[7:3];
    res.robid  = tmp[15:8];
    res.rd     = tmp[21:16];
    res.result = $random(seed);
    return res;
  endfunction

  always_comb begin
    for (int i = 0; i < `WB_NUM_LANES; i++) begin
      model_valid[i] = model_q[i].valid;
    end
    win = highest_valid(model_valid);
    model_cdb = '0;
    model_stall = model_valid;
    for (int i = 0; i < `WB_NUM_LANES; i++) begin
      if (i == win) begin
        model_cdb = model_q[i];
        model_stall[i] = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      check_en <= 1'b1;
    end
    if (!rst_n || rob_flush) begin
      for (int i = 0; i < `WB_NUM_LANES; i++) begin
        model_q[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < `WB_NUM_LANES; i++) begin
        if (!model_stall[i]) begin
          model_q[i] <= (i == 0 && csr_in.valid) ? csr_in : src[i];
        end
      end
    end
    if (model_cdb.valid) begin
      last_rd <= model_cdb.rd;
      if (!model_cdb.error) begin
        shadow[model_cdb.rd]  <= model_cdb.result;
        written[model_cdb.rd] <= 1'b1;
      end
    end
  end

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
    errors++;
    $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    $display("FAIL: see errors above");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(string msg);
    errors++;
    $display("%s (at %0t ns)", msg, $time);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    assert (act === exp) else report_mismatch(name, exp, act);
  endtask

  // outputs are settled mid-cycle
  always @(negedge clk) begin
    if (check_en) begin
      check_value("cdb_out.valid", 64'(model_cdb.valid), 64'(cdb_out.valid));
      if (model_cdb.valid) begin
        check_value("cdb_out", 64'(model_cdb), 64'(cdb_out));
      end
      check_value("stall", 64'(model_stall), 64'(dut_stall));
      if (written[rf_raddr]) begin
        check_value("rf_rdata", 64'(shadow[rf_raddr]), 64'(rf_rdata));
      end
    end
  end

  // lsq is top priority and never waits
  lsq_never_stalls: assert property (@(posedge clk) disable iff (!check_en) !lsq_stall)
    else abort_run("lsq stall went high although lsq has the top priority");

  stall_has_winner: assert property (@(posedge clk) disable iff (!check_en)
    (|dut_stall) |-> cdb_out.valid)
    else abort_run("a stall was raised while the bus carried no result");

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      abort_run("timeout, the tests did not finish within the cycle limit");
    end
  end

  task automatic step(wb_pkg::lane_vec_t fire, bit csr_fire, bit allow_error);
    @(posedge clk);
    #2;
    rob_flush = 1'b0;
    rf_raddr = last_rd;
    for (int i = 0; i < `WB_NUM_LANES; i++) begin
      // stalled source holds its result
      if (!model_stall[i]) begin
        if (fire[i]) begin
          src[i] = make_result(allow_error);
        end else begin
          src[i].valid = 1'b0;
        end
      end
    end
    if (csr_fire && !src[0].valid && !model_stall[0]) begin
      csr_in = make_result(allow_error);
    end else begin
      csr_in.valid = 1'b0;
    end
  endtask

  task automatic idle_cycles(int n);
    repeat (n) step('0, 1'b0, 1'b0);
  endtask

  // expects all lanes idle
  task automatic send_result(int lane, wb_pkg::wb_result_t res);
    @(posedge clk);
    #2;
    rob_flush = 1'b0;
    rf_raddr = last_rd;
    for (int i = 0; i < `WB_NUM_LANES; i++) begin
      if (i == lane) begin
        src[i] = res;
      end else if (!model_stall[i]) begin
        src[i].valid = 1'b0;
      end
    end
    csr_in.valid = 1'b0;
  endtask

  task automatic flush_cycle();
    @(posedge clk);
    #2;
    rob_flush = 1'b1;
    rf_raddr = last_rd;
    for (int i = 0; i < `WB_NUM_LANES; i++) begin
      src[i].valid = 1'b0;
    end
    csr_in.valid = 1'b0;
  endtask

  initial begin
    rst_n = 1'b0;
    rob_flush = 1'b0;
    rf_raddr = '0;
    csr_in = '0;
    for (int i = 0; i < `WB_NUM_LANES; i++) begin
      src[i] = '0;
    end
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    idle_cycles(4);

    // one result per source
    for (int i = 0; i < `WB_NUM_LANES; i++) begin
      step(wb_pkg::lane_vec_t'(1 << i), 1'b0, 1'b0);
      idle_cycles(3);
    end

    // all sources in the same cycle
    step('1, 1'b0, 1'b0);
    idle_cycles(6);

    // csr alone, then behind lsq
    step('0, 1'b1, 1'b0);
    idle_cycles(3);
    step(5'b10000, 1'b1, 1'b0);
    idle_cycles(4);

    // faulting result to a register written before
    r = make_result(1'b0);
    r.rd = 6'd9;
    send_result(1, r);
    idle_cycles(3);
    r = make_result(1'b0);
    r.error = 1'b1;
    r.rd = 6'd9;
    send_result(2, r);
    idle_cycles(3);

    // flush while three lanes wait
    step('1, 1'b0, 1'b1);
    step('0, 1'b0, 1'b0);
    flush_cycle();
    idle_cycles(3);

    // random mixes
    repeat (300) begin
      rnd = $random(seed);
      if (rnd[11:8] == 4'd0) begin
        flush_cycle();
      end else begin
        step(rnd[4:0], rnd[5], 1'b1);
      end
    end
    idle_cycles(10);

    if (errors == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "errors found");
    end
  end

endmodule

`default_nettype wire

// ==== wb_top.sv ====
////////////////////////////////////////
// writeback stage top
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "wb_settings.svh"

module wb_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rob_flush,

  // execution sources
  input  wb_pkg::wb_result_t scalu0_in,
  input  wb_pkg::wb_result_t scalu1_in,
  input  wb_pkg::wb_result_t mcalu0_in,
  input  wb_pkg::wb_result_t mcalu1_in,
  input  wb_pkg::wb_result_t lsq_in,
  input  wb_pkg::wb_result_t csr_in,

  // back-pressure, csr has none
  output logic               scalu0_stall,
  output logic               scalu1_stall,
  output logic               mcalu0_stall,
  output logic               mcalu1_stall,
  output logic               lsq_stall,

  // common data bus
  output wb_pkg::wb_result_t cdb_out,

  // register file read port
  input  wb_pkg::rd_t        rf_raddr,
  output wb_pkg::data_t      rf_rdata
);

  wb_pkg::wb_result_t lanes_q [`WB_NUM_LANES];
  wb_pkg::wb_result_t cdb;
  wb_pkg::lane_vec_t  stall;

  wb_lanes u_lanes (
    .clk       (clk),
    .rst_n     (rst_n),
    .rob_flush (rob_flush),
    .scalu0_in (scalu0_in),
    .scalu1_in (scalu1_in),
    .mcalu0_in (mcalu0_in),
    .mcalu1_in (mcalu1_in),
    .lsq_in    (lsq_in),
    .csr_in    (csr_in),
    .stall     (stall),
    .lanes_q   (lanes_q)
  );

  wb_arbiter u_arbiter (
    .lanes_q (lanes_q),
    .cdb     (cdb),
    .stall   (stall)
  );

  wb_cdb_rf u_cdb_rf (
    .clk      (clk),
    .cdb      (cdb),
    .cdb_out  (cdb_out),
    .rf_raddr (rf_raddr),
    .rf_rdata (rf_rdata)
  );

  // lane order of the stall vector
  assign scalu0_stall = stall[0];
  assign scalu1_stall = stall[1];
  assign mcalu0_stall = stall[2];
  assign mcalu1_stall = stall[3];
  assign lsq_stall    = stall[4];

endmodule

`default_nettype wire

// ==== wb_cdb_rf.sv ====
////////////////////////////////////////
// cdb drive and register file
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "wb_settings.svh"

module wb_cdb_rf (
  input  logic               clk,

  // arbitrated result
  input  wb_pkg::wb_result_t cdb,
  output wb_pkg::wb_result_t cdb_out,

  // read port
  input  wb_pkg::rd_t        rf_raddr,
  output wb_pkg::data_t      rf_rdata
);

  localparam int rf_depth = 1 << `WB_RD_W;

  wb_pkg::data_t rf_mem [rf_depth];
  logic          rf_we;

  // to the rob
  assign cdb_out = cdb;

  // faulting results never reach the register file
  assign rf_we = cdb.valid && !cdb.error;

  always_ff @(posedge clk) begin
    if (rf_we) begin
      rf_mem[cdb.rd] <= cdb.result;
    end
  end

  // async read
  assign rf_rdata = rf_mem[rf_raddr];

endmodule

`default_nettype wire

// ==== wb_arbiter.sv ====
////////////////////////////////////////
// writeback priority select
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "wb_settings.svh"

module wb_arbiter (
  input  wb_pkg::wb_result_t lanes_q [`WB_NUM_LANES],
  output wb_pkg::wb_result_t cdb,
  output wb_pkg::lane_vec_t  stall
);

  wb_pkg::lane_vec_t valid_vec;
  wb_pkg::lane_vec_t grant;

  always_comb begin
    for (int i = 0; i < `WB_NUM_LANES; i++) begin
      valid_vec[i] = lanes_q[i].valid;
    end
  end

  // fixed order, lsq > mcalu1 > mcalu0 > scalu1 > scalu0
  // higher index is scanned later and so overrides
  always_comb begin
    grant = '0;
    for (int i = 0; i < `WB_NUM_LANES; i++) begin
      if (valid_vec[i]) begin
        grant    = '0;
        grant[i] = 1'b1;
      end
    end
  end

  // bus mux, all zero and so invalid when no lane holds a result
  always_comb begin
    cdb = '0;
    for (int i = 0; i < `WB_NUM_LANES; i++) begin
      if (grant[i]) begin
        cdb = lanes_q[i];
      end
    end
  end

  // every valid loser holds its source
  assign stall = valid_vec & ~grant;

endmodule

`default_nettype wire

// ==== wb_lanes.sv ====
////////////////////////////////////////
// writeback lane registers
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "wb_settings.svh"

module wb_lanes (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rob_flush,

  // execution sources
  input  wb_pkg::wb_result_t    scalu0_in,
  input  wb_pkg::wb_result_t    scalu1_in,
  input  wb_pkg::wb_result_t    mcalu0_in,
  input  wb_pkg::wb_result_t    mcalu1_in,
  input  wb_pkg::wb_result_t    lsq_in,
  input  wb_pkg::wb_result_t    csr_in,

  // per-lane stall from the arbiter
  input  wb_pkg::lane_vec_t     stall,

  // held results, index 0 scalu0 .. 4 lsq
  output wb_pkg::wb_result_t    lanes_q [`WB_NUM_LANES]
);

  wb_pkg::wb_result_t lane_in [`WB_NUM_LANES];

  // csr borrows the scalu0 lane
  // producer never fires csr together with scalu0 or under its stall
  assign lane_in[0] = csr_in.valid ? csr_in : scalu0_in;
  assign lane_in[1] = scalu1_in;
  assign lane_in[2] = mcalu0_in;
  assign lane_in[3] = mcalu1_in;
  assign lane_in[4] = lsq_in;

  always_ff @(posedge clk) begin
    if (!rst_n || rob_flush) begin
      // drop everything pending, payload left as is
      for (int i = 0; i < `WB_NUM_LANES; i++) begin
        lanes_q[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < `WB_NUM_LANES; i++) begin
        // stalled lane keeps its result, an idle load empties it
        if (!stall[i]) begin
          lanes_q[i] <= lane_in[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== wb_pkg.sv ====
////////////////////////////////////////
// writeback types
////////////////////////////////////////
`default_nettype none

`include "wb_settings.svh"

package wb_pkg;

  typedef logic [`WB_DATA_W-1:0]   data_t;
  typedef logic [`WB_RD_W-1:0]     rd_t;
  typedef logic [`WB_ROBID_W-1:0]  robid_t;
  typedef logic [`WB_ECAUSE_W-1:0] ecause_t;

  // bit 0 scalu0 .. bit 4 lsq
  typedef logic [`WB_NUM_LANES-1:0] lane_vec_t;

  // one result as it travels source -> lane -> cdb
  typedef struct packed {
    logic    valid;
    logic    error;
    ecause_t ecause;
    robid_t  robid;
    rd_t     rd;
    data_t   result;
  } wb_result_t;

endpackage

`default_nettype wire

// ==== wb_settings.svh ====
////////////////////////////////////////
// writeback widths
////////////////////////////////////////
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// result payload
`define WB_DATA_W 32

// physical register index, 64 entries
`define WB_RD_W 6

`define WB_ROBID_W 8
`define WB_ECAUSE_W 5

// scalu0, scalu1, mcalu0, mcalu1, lsq
`define WB_NUM_LANES 5

`endif
